/* lsu_pkg.sv */
// load/store unit shared types
// widths, access sizes and channel payloads

package lsu_pkg;

    // data word width in bits
    localparam int XLEN = 32;

    // byte address width in bits
    localparam int ADDR_W = 32;

    // access size of one request
    typedef enum logic [1:0] {
        SIZE_BYTE = 2'd0,
        SIZE_HALF = 2'd1,
        SIZE_WORD = 2'd2
    } access_size_e;

    // request from the outside
    // wdata is taken from its low lanes for byte and half stores
    typedef struct packed {
        // 1 = store, 0 = load
        logic              is_store;
        access_size_e      size;
        // loads only, sign extend the byte or half
        logic              sign_ext;
        logic [ADDR_W-1:0] addr;
        logic [XLEN-1:0]   wdata;
    } mem_req_t;

    // response, one per request and in request order
    typedef struct packed {
        // load result, zero on stores and on faults
        logic [XLEN-1:0] rdata;
        // misaligned access, memory left untouched
        logic            fault;
    } mem_rsp_t;

endpackage

/* lsu_skid_buffer.sv */
// two-entry valid/ready buffer
`timescale 1ns/10ps

module lsu_skid_buffer #(
    parameter type payload_t = logic [31:0]
) (
    input  logic     clk,
    input  logic     i_rst_n,
    // upstream side
    input  logic     i_valid,
    input  payload_t i_data,
    output logic     o_ready,
    // downstream side
    output logic     o_valid,
    output payload_t o_data,
    input  logic     i_ready
);

    // second entry, only filled while the output entry is stalled
    payload_t skid_q;
    logic     skid_vld_q;

    logic     push;
    logic     pop;
    logic     main_vld_n;
    logic     skid_vld_n;
    logic     main_load;

    assign push = i_valid && o_ready;
    assign pop  = o_valid && i_ready;

    // output entry may take new data when empty or leaving this cycle
    assign main_load = !o_valid || pop;

    always_comb begin
        main_vld_n = o_valid;
        skid_vld_n = skid_vld_q;
        if (skid_vld_q) begin
            // ready is low here, so no push; skid moves forward on pop
            if (pop) begin
                skid_vld_n = 1'b0;
            end
        end else if (main_load) begin
            main_vld_n = push;
        end else if (push) begin
            skid_vld_n = 1'b1;
        end
    end

    // ready is a flop, low in reset and high while the skid entry is free
    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            o_valid    <= 1'b0;
            skid_vld_q <= 1'b0;
            o_ready    <= 1'b0;
        end else begin
            o_valid    <= main_vld_n;
            skid_vld_q <= skid_vld_n;
            o_ready    <= !skid_vld_n;
        end
    end

    always_ff @(posedge clk) begin
        if (skid_vld_q) begin
            if (pop) begin
                o_data <= skid_q;
            end
        end else if (main_load) begin
            if (push) begin
                o_data <= i_data;
            end
        end else if (push) begin
            skid_q <= i_data;
        end
    end

endmodule

/* lsu_ctrl_fsm.sv */
// load/store sequencing FSM
`timescale 1ns/10ps

module lsu_ctrl_fsm (
    input  logic                     clk,
    input  logic                     i_rst_n,
    // request buffer head
    input  logic                     i_req_valid,
    input  lsu_pkg::mem_req_t        i_req,
    output logic                     o_req_ready,
    // held request and aligner status
    output lsu_pkg::mem_req_t        o_held_req,
    input  logic                     i_misaligned,
    input  logic [lsu_pkg::XLEN-1:0] i_load_data,
    // memory and timer
    output logic                     o_mem_en,
    output logic                     o_mem_we,
    output logic                     o_timer_start,
    input  logic                     i_timer_done,
    output logic                     o_capture,
    // response buffer
    output logic                     o_rsp_valid,
    output lsu_pkg::mem_rsp_t        o_rsp,
    input  logic                     i_rsp_ready
);

    typedef enum logic [1:0] {
        ST_IDLE    = 2'd0,
        ST_READ    = 2'd1,
        ST_WRITE   = 2'd2,
        ST_RESPOND = 2'd3
    } state_e;

    state_e state_q;
    state_e state_n;
    // a request sits in the held register, waiting for dispatch
    logic   held_vld_q;
    logic   mem_en_q;
    logic   mem_we_q;
    logic   accept;
    logic   word_store;

    assign accept     = i_req_valid && o_req_ready;
    assign word_store = o_held_req.is_store && (o_held_req.size == lsu_pkg::SIZE_WORD);

    // one request at a time, pop only when idle and empty
    assign o_req_ready = (state_q == ST_IDLE) && !held_vld_q;

    always_comb begin
        state_n = state_q;
        case (state_q)
            ST_IDLE: begin
                // misaligned check needs the held request, so dispatch a cycle later
                if (held_vld_q) begin
                    if (i_misaligned) begin
                        state_n = ST_RESPOND;
                    end else if (word_store) begin
                        state_n = ST_WRITE;
                    end else begin
                        // loads, and the read half of byte/half stores
                        state_n = ST_READ;
                    end
                end
            end
            ST_READ: begin
                if (i_timer_done) begin
                    state_n = o_held_req.is_store ? ST_WRITE : ST_RESPOND;
                end
            end
            ST_WRITE: begin
                if (i_timer_done) begin
                    state_n = ST_RESPOND;
                end
            end
            ST_RESPOND: begin
                if (i_rsp_ready) begin
                    state_n = ST_IDLE;
                end
            end
            default: begin
                state_n = ST_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            state_q    <= ST_IDLE;
            held_vld_q <= 1'b0;
            mem_en_q   <= 1'b0;
            mem_we_q   <= 1'b0;
        end else begin
            state_q <= state_n;
            if (accept) begin
                held_vld_q <= 1'b1;
            end else if (state_q == ST_IDLE && held_vld_q) begin
                held_vld_q <= 1'b0;
            end
            // one enable pulse in the first cycle of each access state
            mem_en_q <= (state_n == ST_READ || state_n == ST_WRITE) && (state_n != state_q);
            mem_we_q <= (state_n == ST_WRITE) && (state_q != ST_WRITE);
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            o_held_req <= i_req;
        end
    end

    assign o_mem_en      = mem_en_q;
    assign o_mem_we      = mem_we_q;
    // timer runs alongside every memory access
    assign o_timer_start = mem_en_q;
    // old word is taken when the read completes
    assign o_capture     = (state_q == ST_READ) && i_timer_done;

    assign o_rsp_valid = (state_q == ST_RESPOND);
    assign o_rsp.fault = i_misaligned;
    // data only for a good load
    assign o_rsp.rdata = (i_misaligned || o_held_req.is_store) ? '0 : i_load_data;

endmodule

/* lsu_wait_timer.sv */
// memory wait-state timer
`timescale 1ns/10ps

module lsu_wait_timer #(
    parameter int WAIT_CYCLES = 2
) (
    input  logic clk,
    input  logic i_rst_n,
    input  logic i_start,
    output logic o_done
);

    localparam int CNT_W = (WAIT_CYCLES > 0) ? $clog2(WAIT_CYCLES + 1) : 1;

    logic [CNT_W-1:0] cnt_q;
    logic             busy_q;

    // loaded on start, counts down to zero, then done for one cycle
    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            busy_q <= 1'b0;
            cnt_q  <= '0;
        end else if (i_start) begin
            busy_q <= 1'b1;
            cnt_q  <= CNT_W'(WAIT_CYCLES);
        end else if (busy_q) begin
            if (cnt_q == '0) begin
                busy_q <= 1'b0;
            end else begin
                cnt_q <= cnt_q - 1'b1;
            end
        end
    end

    // WAIT_CYCLES+1 cycles after start
    assign o_done = busy_q && (cnt_q == '0);

endmodule

/* lsu_align.sv */
// byte lane alignment and extension
`timescale 1ns/10ps

module lsu_align #(
    parameter int MEM_WORDS = 256
) (
    input  logic                     clk,
    input  logic                     i_rst_n,
    input  lsu_pkg::mem_req_t        i_req,
    input  logic [lsu_pkg::XLEN-1:0] i_rdata,
    input  logic                     i_capture,
    output logic [IDX_W-1:0]         o_word_index,
    output logic [lsu_pkg::XLEN-1:0] o_wdata,
    output logic [lsu_pkg::XLEN-1:0] o_load_data,
    output logic                     o_misaligned
);

    localparam int IDX_W = (MEM_WORDS > 1) ? $clog2(MEM_WORDS) : 1;

    logic [1:0]               offset;
    logic [lsu_pkg::XLEN-1:0] mask;
    logic [4:0]               shift;
    // old word from memory, kept for merge and load extract
    logic [lsu_pkg::XLEN-1:0] held_word_q;
    logic [lsu_pkg::XLEN-1:0] lanes;
    logic                     ext_bit;

    assign offset = i_req.addr[1:0];

    // high address bits above the array depth are dropped
    assign o_word_index = i_req.addr[IDX_W+1:2];

    // lanes touched by the access
    always_comb begin
        case (i_req.size)
            lsu_pkg::SIZE_BYTE: mask = 32'h0000_00ff << {offset, 3'b000};
            lsu_pkg::SIZE_HALF: mask = offset[1] ? 32'hffff_0000 : 32'h0000_ffff;
            default:            mask = 32'hffff_ffff;
        endcase
    end

    // byte offset to bit shift
    assign shift = {offset, 3'b000};

    // half needs even offset, word needs offset zero
    always_comb begin
        case (i_req.size)
            lsu_pkg::SIZE_BYTE: o_misaligned = 1'b0;
            lsu_pkg::SIZE_HALF: o_misaligned = offset[0];
            default:            o_misaligned = (offset != 2'b00);
        endcase
    end

    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            held_word_q <= '0;
        end else if (i_capture) begin
            held_word_q <= i_rdata;
        end
    end

    // store merge, word mask passes wdata straight through
    assign o_wdata = (held_word_q & ~mask) | ((i_req.wdata << shift) & mask);

    // load lanes moved down to bit 0
    assign lanes = (held_word_q & mask) >> shift;

    assign ext_bit = i_req.sign_ext &&
                     ((i_req.size == lsu_pkg::SIZE_HALF) ? lanes[15] : lanes[7]);

    always_comb begin
        case (i_req.size)
            lsu_pkg::SIZE_BYTE: o_load_data = {{24{ext_bit}}, lanes[7:0]};
            lsu_pkg::SIZE_HALF: o_load_data = {{16{ext_bit}}, lanes[15:0]};
            default:            o_load_data = lanes;
        endcase
    end

endmodule

/* lsu_word_mem.sv */
// word memory, registered read
`timescale 1ns/10ps

module lsu_word_mem #(
    parameter int MEM_WORDS = 256
) (
    input  logic                     clk,
    input  logic                     i_en,
    input  logic                     i_we,
    input  logic [IDX_W-1:0]         i_word_index,
    input  logic [lsu_pkg::XLEN-1:0] i_wdata,
    output logic [lsu_pkg::XLEN-1:0] o_rdata
);

    localparam int IDX_W = (MEM_WORDS > 1) ? $clog2(MEM_WORDS) : 1;

    // contents come up unknown
    logic [lsu_pkg::XLEN-1:0] mem_q [MEM_WORDS];

    // read data holds until the next read
    always_ff @(posedge clk) begin
        if (i_en) begin
            if (i_we) begin
                mem_q[i_word_index] <= i_wdata;
            end else begin
                o_rdata <= mem_q[i_word_index];
            end
        end
    end

endmodule

/* lsu_top.sv */
// load/store unit top level
`timescale 1ns/10ps

module lsu_top #(
    parameter int MEM_WORDS   = 256,
    parameter int WAIT_CYCLES = 2
) (
    input  logic              clk,
    input  logic              i_rst_n,
    // request channel
    input  logic              i_req_valid,
    output logic              o_req_ready,
    input  lsu_pkg::mem_req_t i_req,
    // response channel
    output logic              o_rsp_valid,
    input  logic              i_rsp_ready,
    output lsu_pkg::mem_rsp_t o_rsp
);

    localparam int IDX_W = (MEM_WORDS > 1) ? $clog2(MEM_WORDS) : 1;

    // request buffer to FSM
    logic                     req_vld;
    logic                     req_pop;
    lsu_pkg::mem_req_t        req_head;
    lsu_pkg::mem_req_t        held_req;

    // FSM to response buffer
    logic                     rsp_vld;
    logic                     rsp_rdy;
    lsu_pkg::mem_rsp_t        rsp_data;

    // memory access path
    logic                     mem_en;
    logic                     mem_we;
    logic                     timer_start;
    logic                     timer_done;
    logic                     capture;
    logic                     misaligned;
    logic [IDX_W-1:0]         word_index;
    logic [lsu_pkg::XLEN-1:0] mem_wdata;
    logic [lsu_pkg::XLEN-1:0] mem_rdata;
    logic [lsu_pkg::XLEN-1:0] load_data;

    lsu_skid_buffer #(
        .payload_t(lsu_pkg::mem_req_t)
    ) req_buf_i (
        .clk     (clk),
        .i_rst_n (i_rst_n),
        .i_valid (i_req_valid),
        .i_data  (i_req),
        .o_ready (o_req_ready),
        .o_valid (req_vld),
        .o_data  (req_head),
        .i_ready (req_pop)
    );

    lsu_ctrl_fsm ctrl_fsm_i (
        .clk           (clk),
        .i_rst_n       (i_rst_n),
        .i_req_valid   (req_vld),
        .i_req         (req_head),
        .o_req_ready   (req_pop),
        .o_held_req    (held_req),
        .i_misaligned  (misaligned),
        .i_load_data   (load_data),
        .o_mem_en      (mem_en),
        .o_mem_we      (mem_we),
        .o_timer_start (timer_start),
        .i_timer_done  (timer_done),
        .o_capture     (capture),
        .o_rsp_valid   (rsp_vld),
        .o_rsp         (rsp_data),
        .i_rsp_ready   (rsp_rdy)
    );

    lsu_wait_timer #(
        .WAIT_CYCLES(WAIT_CYCLES)
    ) wait_timer_i (
        .clk     (clk),
        .i_rst_n (i_rst_n),
        .i_start (timer_start),
        .o_done  (timer_done)
    );

    lsu_align #(
        .MEM_WORDS(MEM_WORDS)
    ) align_i (
        .clk          (clk),
        .i_rst_n      (i_rst_n),
        .i_req        (held_req),
        .i_rdata      (mem_rdata),
        .i_capture    (capture),
        .o_word_index (word_index),
        .o_wdata      (mem_wdata),
        .o_load_data  (load_data),
        .o_misaligned (misaligned)
    );

    lsu_word_mem #(
        .MEM_WORDS(MEM_WORDS)
    ) word_mem_i (
        .clk          (clk),
        .i_en         (mem_en),
        .i_we         (mem_we),
        .i_word_index (word_index),
        .i_wdata      (mem_wdata),
        .o_rdata      (mem_rdata)
    );

    lsu_skid_buffer #(
        .payload_t(lsu_pkg::mem_rsp_t)
    ) rsp_buf_i (
        .clk     (clk),
        .i_rst_n (i_rst_n),
        .i_valid (rsp_vld),
        .i_data  (rsp_data),
        .o_ready (rsp_rdy),
        .o_valid (o_rsp_valid),
        .o_data  (o_rsp),
        .i_ready (i_rsp_ready)
    );

endmodule

/* tb_lsu_ref.svh */
// load/store unit reference model
`ifndef TB_LSU_REF_SVH
`define TB_LSU_REF_SVH

// byte image of the DUT memory, byte 0 is the low lane of word 0
logic [7:0] ref_mem [MEM_WORDS*4];

// mismatches and other failures seen so far
int error_count;

// applies one request to the byte image and returns the expected response
function automatic lsu_pkg::mem_rsp_t ref_access(input lsu_pkg::mem_req_t req);
    lsu_pkg::mem_rsp_t rsp;
    logic [31:0]       val;
    int                base;
    int                off;
    int                nbytes;
    rsp = '0;
    val = '0;
    off = int'(req.addr[1:0]);
    // word number wraps at the memory depth, upper address bits drop out
    base = int'((req.addr >> 2) % MEM_WORDS) * 4;
    case (req.size)
        lsu_pkg::SIZE_BYTE: nbytes = 1;
        lsu_pkg::SIZE_HALF: nbytes = 2;
        default:            nbytes = 4;
    endcase
    // an access must start on a multiple of its own size
    if (off % nbytes != 0) begin
        rsp.fault = 1'b1;
        return rsp;
    end
    if (req.is_store) begin
        // only the low lanes of wdata are written
        for (int i = 0; i < nbytes; i++) begin
            ref_mem[base + off + i] = req.wdata[8*i +: 8];
        end
    end else begin
        for (int i = 0; i < nbytes; i++) begin
            val[8*i +: 8] = ref_mem[base + off + i];
        end
        // copy the top bit of the loaded lanes into the unused bytes
        if (req.sign_ext && nbytes < 4 && val[8*nbytes-1]) begin
            for (int i = nbytes; i < 4; i++) begin
                val[8*i +: 8] = 8'hff;
            end
        end
        rsp.rdata = val;
    end
    return rsp;
endfunction

// compares one value against its expected value
task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
        error_count++;
        $display("CHECK FAILED t=%0t %s: got 0x%08h, expected 0x%08h",
                 $time, name, got, exp);
    end
endtask

`endif

/* tb_lsu.sv */
// load/store unit testbench
`timescale 1ns/10ps

module tb_lsu;

    localparam int MEM_WORDS   = 256;
    localparam int WAIT_CYCLES = 2;

    // requests issued by each test
    localparam int N_ROUND   = 32;
    localparam int N_MERGE   = 14;
    localparam int N_EXT     = 26;
    localparam int N_FAULT   = 12;
    localparam int N_BP_FILL = 5;
    localparam int N_BP_RAND = 40;
    localparam int N_RANDOM  = 100;
    localparam int N_TOTAL   = N_ROUND + N_MERGE + N_EXT + N_FAULT
                             + N_BP_FILL + N_BP_RAND + N_RANDOM;
    localparam int WATCHDOG_CYCLES = N_TOTAL * (4 * (WAIT_CYCLES + 1) + 10);

    // response ready modes
    localparam int BP_OPEN   = 0;
    localparam int BP_BLOCK  = 1;
    localparam int BP_RANDOM = 2;

    logic              clk;
    logic              i_rst_n;
    logic              i_req_valid;
    logic              o_req_ready;
    lsu_pkg::mem_req_t i_req;
    logic              o_rsp_valid;
    logic              i_rsp_ready;
    lsu_pkg::mem_rsp_t o_rsp;

    integer            seed;
    int                bp_mode;
    int                issued;
    int                received;
    int                test_count;
    int                test_issued0;
    int                test_err0;
    // expected responses in request order
    lsu_pkg::mem_rsp_t exp_q[$];

    `include "tb_lsu_ref.svh"

    lsu_top #(
        .MEM_WORDS   (MEM_WORDS),
        .WAIT_CYCLES (WAIT_CYCLES)
    ) lsu_top_i (
        .clk         (clk),
        .i_rst_n     (i_rst_n),
        .i_req_valid (i_req_valid),
        .o_req_ready (o_req_ready),
        .i_req       (i_req),
        .o_rsp_valid (o_rsp_valid),
        .i_rsp_ready (i_rsp_ready),
        .o_rsp       (o_rsp)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic logic [31:0] rand_word();
        rand_word = $random(seed);
    endfunction

    function automatic lsu_pkg::mem_req_t load_req(input lsu_pkg::access_size_e size,
                                                   input logic sign_ext,
                                                   input logic [31:0] addr);
        lsu_pkg::mem_req_t req;
        req          = '0;
        req.size     = size;
        req.sign_ext = sign_ext;
        req.addr     = addr;
        return req;
    endfunction

    function automatic lsu_pkg::mem_req_t store_req(input lsu_pkg::access_size_e size,
                                                    input logic [31:0] addr,
                                                    input logic [31:0] wdata);
        lsu_pkg::mem_req_t req;
        req          = '0;
        req.is_store = 1'b1;
        req.size     = size;
        req.addr     = addr;
        req.wdata    = wdata;
        return req;
    endfunction

    // any size, sign and offset within words 0..15
    function automatic lsu_pkg::mem_req_t random_req();
        lsu_pkg::mem_req_t req;
        logic [31:0]       r;
        logic [31:0]       hi;
        r            = rand_word();
        hi           = rand_word();
        req.is_store = r[0];
        req.sign_ext = r[1];
        req.size     = lsu_pkg::access_size_e'(2'(r[15:8] % 8'd3));
        // bits above the memory depth are random and must alias
        req.addr     = {hi[31:10], 4'b0000, r[5:2], r[7:6]};
        req.wdata    = rand_word();
        return req;
    endfunction

    // called 1 ns after a rising edge, returns 1 ns after the transfer edge
    task automatic send_req(input lsu_pkg::mem_req_t req);
        i_req_valid = 1'b1;
        i_req       = req;
        while (o_req_ready !== 1'b1) begin
            @(posedge clk);
            #1;
        end
        // transfer happens on the coming edge
        exp_q.push_back(ref_access(req));
        issued++;
        @(posedge clk);
        #1;
        i_req_valid = 1'b0;
    endtask

    task automatic start_test();
        test_issued0 = issued;
        test_err0    = error_count;
    endtask

    task automatic finish_test(input string name);
        while (received < issued) begin
            @(posedge clk);
            #1;
        end
        test_count++;
        $display("test %0d %s: %0d requests, %0d errors", test_count, name,
                 issued - test_issued0, error_count - test_err0);
    endtask

    // response side, ready driven after the edge and outputs sampled mid cycle
    initial begin : rsp_compare
        lsu_pkg::mem_rsp_t exp_rsp;
        logic [31:0]       r;
        logic              rdy_next;
        i_rsp_ready = 1'b0;
        forever begin
            @(negedge clk);
            if (i_rst_n === 1'b1 && o_rsp_valid === 1'b1 && i_rsp_ready) begin
                if (exp_q.size() == 0) begin
                    error_count++;
                    $display("response at t=%0t with no request outstanding", $time);
                end else begin
                    exp_rsp = exp_q.pop_front();
                    check_val("o_rsp.rdata", o_rsp.rdata, exp_rsp.rdata);
                    check_val("o_rsp.fault", 32'(o_rsp.fault), 32'(exp_rsp.fault));
                end
                received++;
            end
            if (bp_mode == BP_RANDOM) begin
                r        = rand_word();
                rdy_next = r[4];
            end else begin
                rdy_next = (bp_mode == BP_OPEN);
            end
            @(posedge clk);
            #1;
            i_rsp_ready = rdy_next;
        end
    end

    initial begin : watchdog
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("timeout: the DUT stopped answering, %0d of %0d responses after %0d cycles",
                 received, issued, WATCHDOG_CYCLES);
        $display("Checks failed");
        $finish;
    end

    initial begin : stimulus
        logic [31:0] word_val;
        seed         = 32'h9b8d_2157;
        i_rst_n      = 1'b0;
        i_req_valid  = 1'b0;
        i_req        = '0;
        bp_mode      = BP_OPEN;
        issued       = 0;
        received     = 0;
        error_count  = 0;
        test_count   = 0;
        repeat (5) @(posedge clk);
        #1;
        i_rst_n = 1'b1;
        @(posedge clk);
        #1;
        // ready registered high one cycle out of reset
        check_val("o_req_ready", 32'(o_req_ready), 32'd1);
        check_val("o_rsp_valid", 32'(o_rsp_valid), 32'd0);

        // words 0..15 written here and used by every later test
        start_test();
        for (int w = 0; w < 16; w++) begin
            send_req(store_req(lsu_pkg::SIZE_WORD, 32'(w * 4), rand_word()));
        end
        for (int w = 0; w < 16; w++) begin
            send_req(load_req(lsu_pkg::SIZE_WORD, 1'b0, 32'(w * 4)));
        end
        finish_test("word round trip");

        start_test();
        send_req(store_req(lsu_pkg::SIZE_WORD, 32'd12, 32'h1122_3344));
        for (int b = 0; b < 4; b++) begin
            // upper bits of wdata are junk and stay out of memory
            send_req(store_req(lsu_pkg::SIZE_BYTE, 32'(12 + b), rand_word()));
            send_req(load_req(lsu_pkg::SIZE_WORD, 1'b0, 32'd12));
        end
        send_req(store_req(lsu_pkg::SIZE_WORD, 32'd12, 32'h5566_7788));
        for (int h = 0; h < 2; h++) begin
            send_req(store_req(lsu_pkg::SIZE_HALF, 32'(12 + 2 * h), rand_word()));
            send_req(load_req(lsu_pkg::SIZE_WORD, 1'b0, 32'd12));
        end
        finish_test("byte and half merge");

        // one word with every lane top bit mixed, one with the opposite
        start_test();
        send_req(store_req(lsu_pkg::SIZE_WORD, 32'd20, 32'h807f_ff01));
        send_req(store_req(lsu_pkg::SIZE_WORD, 32'd24, 32'h7f80_01fe));
        for (int w = 0; w < 2; w++) begin
            for (int s = 0; s < 2; s++) begin
                for (int b = 0; b < 4; b++) begin
                    send_req(load_req(lsu_pkg::SIZE_BYTE, 1'(s), 32'(20 + 4 * w + b)));
                end
                for (int h = 0; h < 2; h++) begin
                    send_req(load_req(lsu_pkg::SIZE_HALF, 1'(s), 32'(20 + 4 * w + 2 * h)));
                end
            end
        end
        finish_test("load extension");

        start_test();
        send_req(store_req(lsu_pkg::SIZE_WORD, 32'd28, 32'hcafe_f00d));
        for (int o = 1; o < 4; o += 2) begin
            send_req(load_req(lsu_pkg::SIZE_HALF, 1'b1, 32'(28 + o)));
            send_req(store_req(lsu_pkg::SIZE_HALF, 32'(28 + o), 32'hffff_ffff));
        end
        for (int o = 1; o < 4; o++) begin
            send_req(load_req(lsu_pkg::SIZE_WORD, 1'b0, 32'(28 + o)));
            send_req(store_req(lsu_pkg::SIZE_WORD, 32'(28 + o), 32'h0000_0000));
        end
        // faulting stores must leave the word as it was
        send_req(load_req(lsu_pkg::SIZE_WORD, 1'b0, 32'd28));
        finish_test("misaligned fault");

        // response side shut, two skid buffers plus the FSM fill with five
        start_test();
        bp_mode = BP_BLOCK;
        repeat (2) begin
            @(posedge clk);
            #1;
        end
        for (int i = 0; i < N_BP_FILL; i++) begin
            send_req(random_req());
        end
        repeat (60) begin
            @(posedge clk);
            #1;
        end
        check_val("o_req_ready", 32'(o_req_ready), 32'd0);
        // oldest response waits at the output while ready stays low
        check_val("o_rsp_valid", 32'(o_rsp_valid), 32'd1);
        bp_mode = BP_RANDOM;
        for (int i = 0; i < N_BP_RAND; i++) begin
            send_req(random_req());
        end
        finish_test("back-pressure");
        bp_mode = BP_OPEN;

        start_test();
        for (int i = 0; i < N_RANDOM; i++) begin
            word_val = rand_word();
            // idle gap now and then
            if (word_val[0]) begin
                @(posedge clk);
                #1;
            end
            send_req(random_req());
        end
        finish_test("random mix");

        if (exp_q.size() != 0) begin
            error_count++;
            $display("%0d expected responses never arrived", exp_q.size());
        end
        $display("summary: %0d tests, %0d requests, %0d responses, %0d errors",
                 test_count, issued, received, error_count);
        if (error_count == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

/* flist.f */
+incdir+.
lsu_pkg.sv
lsu_skid_buffer.sv
lsu_ctrl_fsm.sv
lsu_wait_timer.sv
lsu_align.sv
lsu_word_mem.sv
lsu_top.sv
tb_lsu.sv

/* run.sh */
#!/bin/sh
# build and run the load/store unit testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -Wno-fatal -f flist.f --top-module tb_lsu -o tb_lsu_sim

./obj_dir/tb_lsu_sim > sim.log 2>&1
cat sim.log

if grep -q "Checks failed" sim.log; then
    echo "simulation FAILED"
    exit 1
fi
echo "simulation passed"
